/* build.f */
hdl/bk_mem_pkg.sv
hdl/bk_host_pkg.sv
hdl/backup_ram.sv
hdl/sector_counter.sv
hdl/bk_sequencer.sv
hdl/backup_save_top.sv
sim/sd_host_model.sv
sim/tb_backup_save.sv

/* hdl/backup_ram.sv */
// Battery RAM with a byte port for the console core and a word port for
// the host buffer. A rising edge on format_req writes the default header
// into the first words through the word port.
`default_nettype none

module backup_ram
	import bk_mem_pkg::*;
#(
	parameter int BRAM_ADDR_W = 11
) (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic [BRAM_ADDR_W-1:0]        bram_addr,
	input  byte_t                         bram_data,
	input  logic                          bram_wr,
	output byte_t                         bram_q,
	input  logic                          format_req,
	input  logic [BRAM_ADDR_W-10:0]       sector_sel,
	input  logic [SECTOR_WORD_ADDR_W-1:0] sd_buff_addr,
	input  word_t                         sd_buff_dout,
	input  logic                          sd_buff_wr,
	input  logic                          sd_ack,
	output word_t                         sd_buff_din
);

	localparam int WORD_ADDR_W = BRAM_ADDR_W - 1;
	localparam int DEPTH       = 2 ** WORD_ADDR_W;
	localparam int SECTORS     = 2 ** (BRAM_ADDR_W - 9);
	localparam int SECTOR_BITS = $clog2(SECTORS);
	localparam int FMT_W       = $clog2(HEADER_WORDS);

	// Even byte address in the low lane, odd in the high lane
	byte_t mem_lo [DEPTH];
	byte_t mem_hi [DEPTH];

	logic [WORD_ADDR_W-1:0] core_idx;
	logic                   core_lane;

	logic                   fmt_d;
	logic                   fmt_active;
	logic [FMT_W-1:0]       fmt_idx;

	logic [WORD_ADDR_W-1:0] host_addr;
	logic                   host_we;
	word_t                  host_wdata;

	assign core_idx  = bram_addr[BRAM_ADDR_W-1:1];
	assign core_lane = bram_addr[0];

	//////////////////////////////
	// Format writer

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fmt_d      <= 1'b0;
			fmt_active <= 1'b0;
			fmt_idx    <= '0;
		end else begin
			fmt_d <= format_req;
			if (format_req && !fmt_d) begin
				fmt_active <= 1'b1;
				fmt_idx    <= '0;
			end else if (fmt_active) begin
				fmt_idx <= fmt_idx + FMT_W'(1);
				if (fmt_idx == FMT_W'(HEADER_WORDS - 1))
					fmt_active <= 1'b0;
			end
		end
	end

	// Word port belongs to the format writer while it runs
	assign host_addr  = fmt_active ? WORD_ADDR_W'(fmt_idx)
	                               : {sector_sel[SECTOR_BITS-1:0], sd_buff_addr};
	assign host_we    = fmt_active || (sd_buff_wr && sd_ack);
	assign host_wdata = fmt_active ? HEADER_DEFAULT[fmt_idx] : sd_buff_dout;

	//////////////////////////////
	// Memory array

	always_ff @(posedge clk_sys) begin
		if (bram_wr && !core_lane)
			mem_lo[core_idx] <= bram_data;
		if (bram_wr && core_lane)
			mem_hi[core_idx] <= bram_data;
		if (host_we) begin
			mem_lo[host_addr] <= host_wdata[BYTE_W-1:0];
			mem_hi[host_addr] <= host_wdata[WORD_W-1:BYTE_W];
		end

		// Both read ports are registered
		bram_q      <= core_lane ? mem_hi[core_idx] : mem_lo[core_idx];
		sd_buff_din <= {mem_hi[host_addr], mem_lo[host_addr]};
	end

	// Host must not stream into the buffer while the header goes in
	a_no_host_wr_in_format: assert property (@(posedge clk_sys) disable iff (reset)
		fmt_active |-> !(sd_buff_wr && sd_ack))
		else $error("host wrote the buffer while the header was being formatted");

endmodule

`default_nettype wire

/* hdl/backup_save_top.sv */
// Backup RAM save and load block of the console core.
// Connects the core byte port and the host sector interface to the
// sequencer, the sector counter and the dual-port RAM.
`default_nettype none

module backup_save_top
	import bk_mem_pkg::*;
	import bk_host_pkg::*;
#(
	parameter int BRAM_ADDR_W = 11
) (
	input  logic                          clk_sys,
	input  logic                          reset,

	// Core side
	input  logic [BRAM_ADDR_W-1:0]        bram_addr,
	input  byte_t                         bram_data,
	input  logic                          bram_wr,
	output byte_t                         bram_q,

	// Host side
	output lba_t                          sd_lba,
	output logic                          sd_rd,
	output logic                          sd_wr,
	input  logic                          sd_ack,
	input  logic [SECTOR_WORD_ADDR_W-1:0] sd_buff_addr,
	input  word_t                         sd_buff_dout,
	output word_t                         sd_buff_din,
	input  logic                          sd_buff_wr,

	// Control and status
	input  logic                          img_mounted,
	input  logic                          img_readonly,
	input  logic                          load_req,
	input  logic                          save_req,
	input  logic                          format_req,
	input  logic                          autosave,
	input  logic                          osd_open,
	output logic                          busy,
	output logic                          pending
);

	localparam int SECTOR_BITS = BRAM_ADDR_W - 9;

	logic sector_step;
	logic sector_clear;
	logic last_sector;

	bk_sequencer u_sequencer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.load_req     (load_req),
		.save_req     (save_req),
		.autosave     (autosave),
		.osd_open     (osd_open),
		.bram_wr      (bram_wr),
		.sd_ack       (sd_ack),
		.last_sector  (last_sector),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.busy         (busy),
		.pending      (pending),
		.sector_step  (sector_step),
		.sector_clear (sector_clear)
	);

	sector_counter #(
		.BRAM_ADDR_W (BRAM_ADDR_W)
	) u_sector_counter (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sector_step  (sector_step),
		.sector_clear (sector_clear),
		.sd_lba       (sd_lba),
		.last_sector  (last_sector)
	);

	// Low bits of the block address pick the sector inside the RAM
	backup_ram #(
		.BRAM_ADDR_W (BRAM_ADDR_W)
	) u_backup_ram (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bram_addr    (bram_addr),
		.bram_data    (bram_data),
		.bram_wr      (bram_wr),
		.bram_q       (bram_q),
		.format_req   (format_req),
		.sector_sel   (sd_lba[SECTOR_BITS-1:0]),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_ack       (sd_ack),
		.sd_buff_din  (sd_buff_din)
	);

endmodule

`default_nettype wire

/* hdl/bk_host_pkg.sv */
// Sector transfer protocol towards the host.
// Block address width and the direction of a running transfer.
`default_nettype none

package bk_host_pkg;

	// Host block address
	localparam int LBA_W = 32;

	typedef logic [LBA_W-1:0] lba_t;

	// Load reads the image into RAM, save writes RAM out to the image
	typedef enum logic {
		DIR_LOAD = 1'b0,
		DIR_SAVE = 1'b1
	} xfer_dir_t;

endpackage

`default_nettype wire

/* hdl/bk_mem_pkg.sv */
// Geometry of the battery RAM and the default save header.
// Shared by the RAM and the top level for bus widths and payload types.
`default_nettype none

package bk_mem_pkg;

	// Core side is one byte wide
	localparam int BYTE_W = 8;

	// Host buffer word
	localparam int WORD_W = 16;

	// 256 words of 16 bits in one 512 byte sector
	localparam int SECTOR_WORD_ADDR_W = 8;

	localparam int HEADER_WORDS = 4;

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [WORD_W-1:0] word_t;

	// Default header in word order, index 0 first
	// Reads back as the bytes "HUBM" followed by 00h 88h 10h 80h
	localparam word_t [HEADER_WORDS-1:0] HEADER_DEFAULT = {
		16'h8010,
		16'h8800,
		16'h4D42,
		16'h5548
	};

endpackage

`default_nettype wire

/* hdl/bk_sequencer.sv */
// Control for backup RAM loads and saves.
// Raises sd_rd or sd_wr per sector, steps the sector counter on each
// falling sd_ack and tracks the dirty flag that drives autosave.
`default_nettype none

module bk_sequencer
	import bk_host_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic load_req,
	input  logic save_req,
	input  logic autosave,
	input  logic osd_open,
	input  logic bram_wr,
	input  logic sd_ack,
	input  logic last_sector,
	output logic sd_rd,
	output logic sd_wr,
	output logic busy,
	output logic pending,
	output logic sector_step,
	output logic sector_clear
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQUEST,
		ST_XFER
	} state_t;

	state_t    state;
	xfer_dir_t dir;
	logic      enabled;

	logic load_d;
	logic load_rise;
	logic save_trig;
	logic save_d;
	logic save_rise;
	logic ack_d;
	logic ack_rise;
	logic ack_fall;
	logic start;
	logic sector_done;

	// Explicit save or dirty RAM with the menu open
	assign save_trig = save_req || (pending && osd_open && autosave);

	//////////////////////////////
	// Edge detection

	// Edges are registered so every action lands one clock later
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_d    <= 1'b0;
			load_rise <= 1'b0;
			save_d    <= 1'b0;
			save_rise <= 1'b0;
			ack_d     <= 1'b0;
			ack_rise  <= 1'b0;
			ack_fall  <= 1'b0;
		end else begin
			load_d    <= load_req;
			load_rise <= load_req && !load_d;
			save_d    <= save_trig;
			save_rise <= save_trig && !save_d;
			ack_d     <= sd_ack;
			ack_rise  <= sd_ack && !ack_d;
			ack_fall  <= !sd_ack && ack_d;
		end
	end

	assign start       = (state == ST_IDLE) && enabled && (load_rise || save_rise);
	assign sector_done = (state == ST_XFER) && ack_fall;

	//////////////////////////////
	// Transfer FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ST_IDLE;
			dir   <= DIR_LOAD;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_REQUEST;
						// Load wins when both arrive together
						dir   <= load_rise ? DIR_LOAD : DIR_SAVE;
					end
				end
				ST_REQUEST: begin
					if (ack_rise)
						state <= ST_XFER;
				end
				ST_XFER: begin
					if (ack_fall)
						state <= last_sector ? ST_IDLE : ST_REQUEST;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign sd_rd = (state == ST_REQUEST) && (dir == DIR_LOAD);
	assign sd_wr = (state == ST_REQUEST) && (dir == DIR_SAVE);
	assign busy  = (state != ST_IDLE);

	// Counter restarts at sector 0 and returns there after the last one
	assign sector_clear = start || (sector_done && last_sector);
	assign sector_step  = sector_done && !last_sector;

	//////////////////////////////
	// Enable and dirty flag

	always_ff @(posedge clk_sys) begin
		if (reset)
			enabled <= 1'b0;
		else if (img_mounted && !img_readonly)
			enabled <= 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			pending <= 1'b0;
		else if (start)
			pending <= 1'b0;
		else if (enabled && !osd_open && bram_wr)
			pending <= 1'b1;
	end

	// Request drops in the clock after the host ack is first seen
	a_req_drops_after_ack: assert property (@(posedge clk_sys) disable iff (reset)
		$past((sd_rd || sd_wr) && sd_ack, 2) |-> !(sd_rd || sd_wr))
		else $error("sector request still high two clocks after sd_ack");

endmodule

`default_nettype wire

/* hdl/sector_counter.sv */
// Sector index of the running transfer, presented as the host block
// address. Cleared when a transfer starts or ends, stepped between sectors.
`default_nettype none

module sector_counter
	import bk_host_pkg::*;
#(
	parameter int BRAM_ADDR_W = 11
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic sector_step,
	input  logic sector_clear,
	output lba_t sd_lba,
	output logic last_sector
);

	localparam int   SECTORS     = 2 ** (BRAM_ADDR_W - 9);
	localparam lba_t LAST_SECTOR = lba_t'(SECTORS - 1);

	always_ff @(posedge clk_sys) begin
		if (reset || sector_clear)
			sd_lba <= '0;
		else if (sector_step)
			sd_lba <= sd_lba + lba_t'(1);
	end

	assign last_sector = (sd_lba == LAST_SECTOR);

	// Sequencer stops stepping at the final sector
	a_lba_in_range: assert property (@(posedge clk_sys) disable iff (reset)
		sd_lba <= LAST_SECTOR)
		else $error("sd_lba stepped beyond the last sector");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the backup RAM testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the testbench stops on an error.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
	--timescale 1ns/100ps \
	--top-module tb_backup_save \
	-f build.f \
	-o tb_backup_save_sim &&
./obj_dir/tb_backup_save_sim ||
{ echo "run_sim: build or simulation returned an error"; exit 1; }

/* sim/sd_host_model.sv */
// Host side of the save image for the backup RAM testbench.
// Answers each sd_rd or sd_wr after ack_delay clocks and streams one whole
// sector. Loads supply a fixed word pattern, saved words are kept for checking.
`default_nettype none

module sd_host_model
	import bk_mem_pkg::*;
	import bk_host_pkg::*;
#(
	parameter int SECTOR_BITS = 2
) (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          sd_rd,
	input  logic                          sd_wr,
	input  lba_t                          sd_lba,
	input  logic [3:0]                    ack_delay,
	input  word_t                         sd_buff_din,
	output logic                          sd_ack,
	output logic [SECTOR_WORD_ADDR_W-1:0] sd_buff_addr,
	output word_t                         sd_buff_dout,
	output logic                          sd_buff_wr
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WORDS = 2 ** SECTOR_WORD_ADDR_W;

	typedef enum logic [1:0] {
		H_IDLE,
		H_DELAY,
		H_STREAM
	} host_state_t;

	host_state_t            state;
	logic                   saving;
	logic [SECTOR_BITS-1:0] sector;
	logic [3:0]             delay;
	int                     word_cnt;

	// Request log and saved image, read by the testbench
	int    req_count;
	lba_t  req_lba_log [0:63];
	logic  req_write_log [0:63];
	word_t saved_words [0:(2**SECTOR_BITS)*WORDS-1];

	// Image content served on a load
	function automatic word_t image_word(input int sec, input int idx);
		return 16'((sec << 12) + idx) ^ 16'hA5A5;
	endfunction

	// Host bus is idle from time zero
	initial begin
		state        = H_IDLE;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
	end

	always @(negedge clk_sys) begin
		if (reset) begin
			state        <= H_IDLE;
			sd_ack       <= 1'b0;
			sd_buff_addr <= '0;
			sd_buff_dout <= '0;
			sd_buff_wr   <= 1'b0;
			req_count    = 0;
		end else begin
			case (state)
				H_IDLE: begin
					if (sd_rd || sd_wr) begin
						req_lba_log[req_count]   = sd_lba;
						req_write_log[req_count] = sd_wr;
						req_count = req_count + 1;
						saving <= sd_wr;
						sector <= sd_lba[SECTOR_BITS-1:0];
						delay  <= ack_delay;
						state  <= H_DELAY;
					end
				end
				H_DELAY: begin
					if (delay <= 4'd1) begin
						sd_ack       <= 1'b1;
						sd_buff_addr <= '0;
						sd_buff_wr   <= !saving;
						sd_buff_dout <= image_word(int'(sector), 0);
						word_cnt     <= 1;
						state        <= H_STREAM;
					end else
						delay <= delay - 4'd1;
				end
				H_STREAM: begin
					// RAM read data trails the address by one clock
					if (saving)
						saved_words[{sector, sd_buff_addr}] <= sd_buff_din;
					if (word_cnt == WORDS) begin
						sd_ack     <= 1'b0;
						sd_buff_wr <= 1'b0;
						state      <= H_IDLE;
					end else begin
						sd_buff_addr <= SECTOR_WORD_ADDR_W'(word_cnt);
						sd_buff_dout <= image_word(int'(sector), word_cnt);
						word_cnt     <= word_cnt + 1;
					end
				end
				default: state <= H_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* sim/tb_backup_save.sv */
// Testbench for the backup RAM save and load block.
// Drives the core port and control inputs on falling edges, answers sector
// requests with sd_host_model and checks format, enable, autosave, save and load.
`default_nettype none

module tb_backup_save
	import bk_mem_pkg::*;
	import bk_host_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          BRAM_ADDR_W = 11;
	localparam int          BYTES       = 2 ** BRAM_ADDR_W;
	localparam int          SECTORS     = 2 ** (BRAM_ADDR_W - 9);
	localparam int          TIMEOUT     = 5000;
	localparam logic [31:0] SEED        = 32'd1560;

	// Header words as the format command stores them
	localparam logic [15:0] FMT_HEADER [4] = '{16'h5548, 16'h4D42, 16'h8800, 16'h8010};

	logic                          clk_sys;
	logic                          reset;
	logic [BRAM_ADDR_W-1:0]        bram_addr;
	byte_t                         bram_data;
	logic                          bram_wr;
	byte_t                         bram_q;
	lba_t                          sd_lba;
	logic                          sd_rd;
	logic                          sd_wr;
	logic                          sd_ack;
	logic [SECTOR_WORD_ADDR_W-1:0] sd_buff_addr;
	word_t                         sd_buff_dout;
	word_t                         sd_buff_din;
	logic                          sd_buff_wr;
	logic                          img_mounted;
	logic                          img_readonly;
	logic                          load_req;
	logic                          save_req;
	logic                          format_req;
	logic                          autosave;
	logic                          osd_open;
	logic                          busy;
	logic                          pending;
	logic [3:0]                    ack_delay;
	logic                          mounted;
	logic [31:0]                   data_rng;
	logic [31:0]                   delay_rng = SEED;
	byte_t                         shadow [BYTES];

	backup_save_top #(.BRAM_ADDR_W(BRAM_ADDR_W)) DUT (.*);

	sd_host_model #(.SECTOR_BITS(BRAM_ADDR_W - 9)) u_host (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Host ack delay of 1 to 8 clocks, redrawn every clock
	always @(negedge clk_sys)
		delay_rng <= xorshift32(delay_rng);
	assign ack_delay = {1'b0, delay_rng[2:0]} + 4'd1;

	// Word the host image holds at a given sector and word address
	function automatic word_t expected_load_word(input int sector, input int word);
		return {4'(sector), 12'(word)} ^ 16'hA5A5;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string test, input logic [31:0] exp,
	                               input logic [31:0] act);
		stop_with_error($sformatf("MISMATCH %s expected %0h actual %0h", test, exp, act));
	endtask

	task automatic write_byte(input int addr, input byte_t data);
		bram_addr = BRAM_ADDR_W'(addr);
		bram_data = data;
		bram_wr   = 1'b1;
		@(negedge clk_sys);
		bram_wr   = 1'b0;
	endtask

	task automatic read_byte(input int addr, output byte_t data);
		bram_addr = BRAM_ADDR_W'(addr);
		@(negedge clk_sys);
		data = bram_q;
	endtask

	task automatic wait_for_busy(input logic level, input string test);
		int cycles;
		cycles = 0;
		while (busy !== level) begin
			if (cycles == TIMEOUT)
				stop_with_error($sformatf("%s: busy did not go to %0b within %0d clocks",
				                          test, level, TIMEOUT));
			@(negedge clk_sys);
			cycles++;
		end
	endtask

	task automatic request_transfer(input logic load, input string test);
		if (load)
			load_req = 1'b1;
		else
			save_req = 1'b1;
		wait_for_busy(1'b1, test);
		load_req = 1'b0;
		save_req = 1'b0;
		wait_for_busy(1'b0, test);
	endtask

	// One request per sector, in order, all in one direction
	task automatic check_request_log(input int base, input logic is_write, input string test);
		assert (u_host.req_count == base + SECTORS)
			else report_mismatch(test, 32'(base + SECTORS), 32'(u_host.req_count));
		for (int i = 0; i < SECTORS; i++) begin
			assert (u_host.req_lba_log[base + i] == lba_t'(i))
				else report_mismatch(test, 32'(i), u_host.req_lba_log[base + i]);
			assert (u_host.req_write_log[base + i] == is_write)
				else stop_with_error({test, ": sector request in the wrong direction"});
		end
	endtask

	//////////////////////////////
	// Protocol checks

	a_no_req_before_mount: assert property (@(posedge clk_sys) disable iff (reset)
		!mounted |-> !(sd_rd || sd_wr))
		else stop_with_error("sector request raised before any image was mounted");

	a_req_only_busy: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd || sd_wr) |-> busy)
		else stop_with_error("sector request raised while busy is low");

	// A transfer opens with a request for sector 0
	a_start_at_zero: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(busy) |-> ((sd_rd || sd_wr) && sd_lba == '0))
		else report_mismatch("start_lba", 32'd0, $sampled(sd_lba));

	a_lba_idle_zero: assert property (@(posedge clk_sys) disable iff (reset)
		!busy |-> (sd_lba == '0))
		else report_mismatch("idle_lba", 32'd0, $sampled(sd_lba));

	//////////////////////////////
	// Stimulus

	initial begin
		byte_t       rd;
		byte_t       exp_byte;
		logic [15:0] hdr_word;
		word_t       exp_word;
		int          base;

		reset        = 1'b1;
		bram_addr    = '0;
		bram_data    = '0;
		bram_wr      = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		load_req     = 1'b0;
		save_req     = 1'b0;
		format_req   = 1'b0;
		autosave     = 1'b0;
		osd_open     = 1'b0;
		mounted      = 1'b0;
		data_rng     = SEED;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;

		assert (!sd_rd && !sd_wr && !busy && !pending)
			else stop_with_error("sd_rd, sd_wr, busy or pending high after reset");

		// Save request without a mounted image
		save_req = 1'b1;
		repeat (20) @(negedge clk_sys);
		save_req = 1'b0;
		assert (!busy) else stop_with_error("save started before any image was mounted");

		// Header appears 6 clocks after the format edge
		format_req = 1'b1;
		repeat (6) @(negedge clk_sys);
		format_req = 1'b0;
		for (int i = 0; i < 8; i++) begin
			hdr_word = FMT_HEADER[i / 2];
			exp_byte = (i % 2) ? hdr_word[15:8] : hdr_word[7:0];
			read_byte(i, rd);
			assert (rd == exp_byte) else report_mismatch("format", 32'(exp_byte), 32'(rd));
		end

		img_mounted = 1'b1;
		mounted     = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		write_byte(8, 8'h3C);
		assert (pending) else stop_with_error("pending stayed low after a core write");

		// Dirty RAM with menu open and autosave on
		base     = u_host.req_count;
		osd_open = 1'b1;
		autosave = 1'b1;
		wait_for_busy(1'b1, "autosave");
		wait_for_busy(1'b0, "autosave");
		assert (!pending) else stop_with_error("pending still high after autosave");
		check_request_log(base, 1'b1, "autosave");
		osd_open = 1'b0;
		autosave = 1'b0;

		for (int i = 0; i < BYTES; i++) begin
			data_rng  = xorshift32(data_rng);
			shadow[i] = data_rng[7:0];
			write_byte(i, shadow[i]);
		end
		base = u_host.req_count;
		request_transfer(1'b0, "save");
		check_request_log(base, 1'b1, "save");
		for (int w = 0; w < BYTES / 2; w++) begin
			exp_word = {shadow[2 * w + 1], shadow[2 * w]};
			assert (u_host.saved_words[w] == exp_word)
				else report_mismatch("save", 32'(exp_word), 32'(u_host.saved_words[w]));
		end

		base = u_host.req_count;
		request_transfer(1'b1, "load");
		check_request_log(base, 1'b0, "load");
		for (int i = 0; i < BYTES; i++) begin
			exp_word = expected_load_word(i / 512, (i % 512) / 2);
			exp_byte = (i % 2) ? exp_word[15:8] : exp_word[7:0];
			read_byte(i, rd);
			assert (rd == exp_byte) else report_mismatch("load", 32'(exp_byte), 32'(rd));
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
